/* sources.f */
hw/mem_sub_pkg.sv
hw/axi_rw_split.sv
hw/bank_dispatch.sv
hw/mem_bank.sv
hw/read_collect.sv
hw/axi_mem_sub_top.sv
verif/axi_mem_sub_tb.sv

/* Makefile */
SIM        := verilator
TOP        := axi_mem_sub_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
SIM_BIN    := sim_$(TOP)
LOG        := sim.log

COMMON_FLAGS := --timing --assert -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS   := --lint-only $(COMMON_FLAGS)
BUILD_FLAGS  := --binary $(COMMON_FLAGS) --Mdir $(BUILD_DIR) -o $(SIM_BIN)

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS)

sim:
	$(SIM) $(BUILD_FLAGS)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || \
		(echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/axi_mem_sub_tb.sv */
module axi_mem_sub_tb;

  import mem_sub_pkg::*;

  localparam int NUM_BANKS  = DEFAULT_NUM_BANKS;
  localparam int BANK_WORDS = DEFAULT_BANK_WORDS;
  localparam int MAX_OUTST  = DEFAULT_MAX_OUTST;
  localparam int MEM_WORDS  = NUM_BANKS * BANK_WORDS;
  localparam int MEM_BYTES  = MEM_WORDS * 4;
  // Byte lanes for the partial writes, one nibble each
  localparam logic [23:0] PART_STRB = 24'h1_6_8_5_A_3;

  // One table row, writes and reads share the layout
  typedef struct packed {
    logic  is_write;
    addr_t addr;
    data_t data;
    strb_t strb;
    int    stall;
    logic  lat_chk;
    data_t exp_data;
    resp_t exp_resp;
    int    test;
    int    acc_cyc;
  } entry_t;

  logic  clk_i;
  logic  rst_i;
  logic  aw_valid_i;
  addr_t aw_addr_i;
  logic  aw_ready_o;
  logic  w_valid_i;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  w_ready_o;
  logic  b_valid_o;
  resp_t b_resp_o;
  logic  b_ready_i;
  logic  ar_valid_i;
  addr_t ar_addr_i;
  logic  ar_ready_o;
  logic  r_valid_o;
  data_t r_data_o;
  resp_t r_resp_o;
  logic  r_ready_i;

  entry_t      tbl [$];
  // Reads accepted by the DUT and not yet returned, oldest first
  entry_t      exp_q [$];
  logic [7:0]  model_mem [MEM_BYTES];
  logic [31:0] lfsr = 32'd70423;
  logic        tbl_built = 1'b0;
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;

  axi_mem_sub_top #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS),
    .MAX_OUTST  (MAX_OUTST)
  ) axi_mem_sub_top_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_ready_o  (w_ready_o),
    .b_valid_o  (b_valid_o),
    .b_resp_o   (b_resp_o),
    .b_ready_i  (b_ready_i),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i),
    .ar_ready_o (ar_ready_o),
    .r_valid_o  (r_valid_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_ready_i  (r_ready_i)
  );

  // --------------------------------------------------------------------------
  // Clock, cycle count and watchdog
  // --------------------------------------------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Budget of 50 cycles per table row
  initial begin
    wait (tbl_built);
    repeat (tbl.size() * 50) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", tbl.size() * 50);
    $display("Verification failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Galois LFSR, one step per output bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "full word per bank";
      1:       return "memory sweep";
      2:       return "partial strobes";
      3:       return "out of range";
      4:       return "stalled reads";
      default: return "read latency";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Write row, the model memory takes the strobed bytes
  task automatic add_write(input int test, input addr_t addr, input data_t data,
                           input strb_t strb);
    entry_t e;
    int     base;
    e = '0;
    e.is_write = 1'b1;
    e.addr     = addr;
    e.data     = data;
    e.strb     = strb;
    e.test     = test;
    if (addr >= addr_t'(MEM_BYTES)) begin
      e.exp_resp = RESP_SLVERR;
    end else begin
      e.exp_resp = RESP_OKAY;
      base = int'(addr & ~32'h3);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model_mem[base + b] = data[8*b +: 8];
        end
      end
    end
    tbl.push_back(e);
  endtask

  // Read row, expected word taken from the model at build time
  task automatic add_read(input int test, input addr_t addr, input int stall,
                          input logic lat_chk);
    entry_t e;
    int     base;
    e = '0;
    e.addr    = addr;
    e.stall   = stall;
    e.lat_chk = lat_chk;
    e.test    = test;
    if (addr >= addr_t'(MEM_BYTES)) begin
      e.exp_data = '0;
      e.exp_resp = RESP_SLVERR;
    end else begin
      base = int'(addr & ~32'h3);
      e.exp_data = {model_mem[base + 3], model_mem[base + 2],
                    model_mem[base + 1], model_mem[base]};
      e.exp_resp = RESP_OKAY;
    end
    tbl.push_back(e);
  endtask

  task automatic build_table();
    addr_t part_addr [6];
    // Test 0, one word per bank then read back
    for (int k = 0; k < NUM_BANKS; k++) add_write(0, addr_t'(k * 4), take_bits(32), 4'hF);
    for (int k = 0; k < NUM_BANKS; k++) add_read(0, addr_t'(k * 4), 0, 1'b0);
    // Test 1, fill every word then sweep in address order
    for (int k = 0; k < MEM_WORDS; k++) add_write(1, addr_t'(k * 4), take_bits(32), 4'hF);
    for (int k = 0; k < MEM_WORDS; k++) add_read(1, addr_t'(k * 4), 0, 1'b0);
    // Test 2
    for (int k = 0; k < 6; k++) begin
      part_addr[k] = take_bits(6) << 2;
      add_write(2, part_addr[k], take_bits(32), PART_STRB[4*k +: 4]);
    end
    for (int k = 0; k < 6; k++) add_read(2, part_addr[k], 0, 1'b0);
    // Test 3, these alias to words 0x00, 0x44 and 0xFC
    add_write(3, addr_t'(MEM_BYTES), take_bits(32), 4'hF);
    add_write(3, addr_t'(MEM_BYTES + 'h44), take_bits(32), 4'hF);
    add_write(3, 32'hFFFF_FFFC, take_bits(32), 4'hF);
    add_read(3, addr_t'(MEM_BYTES), 0, 1'b0);
    add_read(3, addr_t'(MEM_BYTES + 'h44), 0, 1'b0);
    add_read(3, 32'hFFFF_FFFC, 0, 1'b0);
    add_read(3, 32'h00, 0, 1'b0);
    add_read(3, 32'h44, 0, 1'b0);
    add_read(3, 32'hFC, 0, 1'b0);
    // Test 4, back-to-back reads with r_ready stalls of 0 to 7 cycles
    for (int k = 0; k < 16; k++) add_read(4, take_bits(6) << 2, int'(take_bits(3)), 1'b0);
    // Test 5
    add_write(5, 32'h20, take_bits(32), 4'hF);
    add_read(5, 32'h20, 0, 1'b1);
    add_write(5, 32'hA4, take_bits(32), 4'hF);
    add_read(5, 32'hA4, 0, 1'b1);
  endtask

  // --------------------------------------------------------------------------
  // Bus drivers, inputs change 10 units after the rising edge
  // --------------------------------------------------------------------------

  task automatic wait_reads_done();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  // Ready is sampled at the falling edge, the transfer is the next rising edge
  task automatic do_write(input entry_t e);
    aw_valid_i = 1'b1;
    aw_addr_i  = e.addr;
    w_valid_i  = 1'b1;
    w_data_i   = e.data;
    w_strb_i   = e.strb;
    do @(negedge clk_i); while (!(aw_ready_o && w_ready_o));
    @(posedge clk_i);
    #10;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    // b_ready_i stays high
    do @(negedge clk_i); while (!b_valid_o);
    check_value("B response", 32'(b_resp_o), 32'(e.exp_resp));
    @(posedge clk_i);
    #10;
  endtask

  task automatic do_read(input entry_t e);
    entry_t p;
    p = e;
    // Latency is only defined with an empty R FIFO
    if (e.lat_chk) wait_reads_done();
    ar_valid_i = 1'b1;
    ar_addr_i  = e.addr;
    do @(negedge clk_i); while (!ar_ready_o);
    p.acc_cyc = cyc;
    exp_q.push_back(p);
    @(posedge clk_i);
    #10;
    ar_valid_i = 1'b0;
  endtask

  // R receiver, holds r_ready low for the head beat's stall count
  initial begin
    int waited;
    waited = 0;
    r_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #10;
      if (exp_q.size() != 0 && waited < exp_q[0].stall) begin
        r_ready_i = 1'b0;
      end else begin
        r_ready_i = 1'b1;
      end
      @(negedge clk_i);
      if (r_valid_o && !r_ready_i) begin
        waited++;
      end else if (r_valid_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t: R beat returned with no read outstanding", $time);
        end else begin
          check_value("R data", r_data_o, exp_q[0].exp_data);
          check_value("R response", 32'(r_resp_o), 32'(exp_q[0].exp_resp));
          if (exp_q[0].lat_chk) begin
            check_value("R latency", 32'(cyc - exp_q[0].acc_cyc), 32'd2);
          end
          void'(exp_q.pop_front());
          waited = 0;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    int err_start;
    int chk_start;
    int tests;
    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    err_start  = 0;
    chk_start  = 0;
    tests      = 0;
    build_table();
    tbl_built = 1'b1;
    repeat (5) @(posedge clk_i);
    #10;
    rst_i = 1'b0;
    for (int i = 0; i < tbl.size(); i++) begin
      if (tbl[i].is_write) do_write(tbl[i]);
      else do_read(tbl[i]);
      // Last row of a test, drain R and report
      if (i == tbl.size() - 1 || tbl[i + 1].test != tbl[i].test) begin
        wait_reads_done();
        tests++;
        $display("Test %0d %s: %0d checks, %0d errors", tbl[i].test,
                 test_name(tbl[i].test), checks - chk_start, errors - err_start);
        chk_start = checks;
        err_start = errors;
      end
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* hw/axi_mem_sub_top.sv */
module axi_mem_sub_top #(
  parameter int NUM_BANKS  = mem_sub_pkg::DEFAULT_NUM_BANKS,
  parameter int BANK_WORDS = mem_sub_pkg::DEFAULT_BANK_WORDS,
  parameter int MAX_OUTST  = mem_sub_pkg::DEFAULT_MAX_OUTST
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // Write address and data
  input  logic               aw_valid_i,
  input  mem_sub_pkg::addr_t aw_addr_i,
  output logic               aw_ready_o,
  input  logic               w_valid_i,
  input  mem_sub_pkg::data_t w_data_i,
  input  mem_sub_pkg::strb_t w_strb_i,
  output logic               w_ready_o,
  // Write response
  output logic               b_valid_o,
  output mem_sub_pkg::resp_t b_resp_o,
  input  logic               b_ready_i,
  // Read address and data
  input  logic               ar_valid_i,
  input  mem_sub_pkg::addr_t ar_addr_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output mem_sub_pkg::data_t r_data_o,
  output mem_sub_pkg::resp_t r_resp_o,
  input  logic               r_ready_i
);

  import mem_sub_pkg::*;

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(BANK_WORDS);

  // --------------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------------

  // Split to dispatcher, write side
  logic  wr_aw_valid;
  addr_t wr_aw_addr;
  logic  wr_aw_ready;
  logic  wr_w_valid;
  data_t wr_w_data;
  strb_t wr_w_strb;
  logic  wr_w_ready;
  logic  wr_b_valid;
  resp_t wr_b_resp;
  logic  wr_b_ready;
  // Split to dispatcher and collector, read side
  logic  rd_ar_valid;
  addr_t rd_ar_addr;
  logic  rd_ar_ready;
  logic  rd_r_valid;
  data_t rd_r_data;
  resp_t rd_r_resp;
  logic  rd_r_ready;
  // Bank array
  logic [NUM_BANKS-1:0]            bank_we;
  logic [NUM_BANKS-1:0]            bank_re;
  logic [NUM_BANKS-1:0][ROW_W-1:0] bank_row;
  data_t [NUM_BANKS-1:0]           bank_wdata;
  strb_t [NUM_BANKS-1:0]           bank_wstrb;
  data_t [NUM_BANKS-1:0]           bank_rdata;
  // Dispatcher to collector
  logic              rd_issue;
  logic [BANK_W-1:0] rd_bank;
  logic              rd_err;
  logic              rd_space;

  axi_rw_split #(
    .MAX_OUTST (MAX_OUTST)
  ) axi_rw_split_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .aw_valid_i    (aw_valid_i),
    .aw_addr_i     (aw_addr_i),
    .aw_ready_o    (aw_ready_o),
    .w_valid_i     (w_valid_i),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_ready_o     (w_ready_o),
    .b_valid_o     (b_valid_o),
    .b_resp_o      (b_resp_o),
    .b_ready_i     (b_ready_i),
    .ar_valid_i    (ar_valid_i),
    .ar_addr_i     (ar_addr_i),
    .ar_ready_o    (ar_ready_o),
    .r_valid_o     (r_valid_o),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .r_ready_i     (r_ready_i),
    .wr_aw_valid_o (wr_aw_valid),
    .wr_aw_addr_o  (wr_aw_addr),
    .wr_aw_ready_i (wr_aw_ready),
    .wr_w_valid_o  (wr_w_valid),
    .wr_w_data_o   (wr_w_data),
    .wr_w_strb_o   (wr_w_strb),
    .wr_w_ready_i  (wr_w_ready),
    .wr_b_valid_i  (wr_b_valid),
    .wr_b_resp_i   (wr_b_resp),
    .wr_b_ready_o  (wr_b_ready),
    .rd_ar_valid_o (rd_ar_valid),
    .rd_ar_addr_o  (rd_ar_addr),
    .rd_ar_ready_i (rd_ar_ready),
    .rd_r_valid_i  (rd_r_valid),
    .rd_r_data_i   (rd_r_data),
    .rd_r_resp_i   (rd_r_resp),
    .rd_r_ready_o  (rd_r_ready)
  );

  bank_dispatch #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS),
    .MAX_OUTST  (MAX_OUTST)
  ) bank_dispatch_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wr_aw_valid_i (wr_aw_valid),
    .wr_aw_addr_i  (wr_aw_addr),
    .wr_aw_ready_o (wr_aw_ready),
    .wr_w_valid_i  (wr_w_valid),
    .wr_w_data_i   (wr_w_data),
    .wr_w_strb_i   (wr_w_strb),
    .wr_w_ready_o  (wr_w_ready),
    .wr_b_valid_o  (wr_b_valid),
    .wr_b_resp_o   (wr_b_resp),
    .wr_b_ready_i  (wr_b_ready),
    .rd_ar_valid_i (rd_ar_valid),
    .rd_ar_addr_i  (rd_ar_addr),
    .rd_ar_ready_o (rd_ar_ready),
    .bank_we_o     (bank_we),
    .bank_re_o     (bank_re),
    .bank_row_o    (bank_row),
    .bank_wdata_o  (bank_wdata),
    .bank_wstrb_o  (bank_wstrb),
    .rd_issue_o    (rd_issue),
    .rd_bank_o     (rd_bank),
    .rd_err_o      (rd_err),
    .rd_space_i    (rd_space)
  );

  // One bank per word lane of the interleave
  for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
    mem_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) mem_bank_i (
      .clk_i   (clk_i),
      .we_i    (bank_we[k]),
      .re_i    (bank_re[k]),
      .row_i   (bank_row[k]),
      .wdata_i (bank_wdata[k]),
      .wstrb_i (bank_wstrb[k]),
      .rdata_o (bank_rdata[k])
    );
  end

  read_collect #(
    .NUM_BANKS (NUM_BANKS),
    .MAX_OUTST (MAX_OUTST)
  ) read_collect_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .issue_i      (rd_issue),
    .bank_i       (rd_bank),
    .err_i        (rd_err),
    .bank_rdata_i (bank_rdata),
    .space_o      (rd_space),
    .r_valid_o    (rd_r_valid),
    .r_data_o     (rd_r_data),
    .r_resp_o     (rd_r_resp),
    .r_ready_i    (rd_r_ready)
  );

endmodule

/* hw/read_collect.sv */
module read_collect #(
  parameter int NUM_BANKS = mem_sub_pkg::DEFAULT_NUM_BANKS,
  parameter int MAX_OUTST = mem_sub_pkg::DEFAULT_MAX_OUTST
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Read issued by the dispatcher this cycle
  input  logic                               issue_i,
  input  logic [$clog2(NUM_BANKS)-1:0]       bank_i,
  input  logic                               err_i,
  input  mem_sub_pkg::data_t [NUM_BANKS-1:0] bank_rdata_i,
  output logic                               space_o,
  // R channel
  output logic                               r_valid_o,
  output mem_sub_pkg::data_t                 r_data_o,
  output mem_sub_pkg::resp_t                 r_resp_o,
  input  logic                               r_ready_i
);

  import mem_sub_pkg::*;

  localparam int PTR_W = (MAX_OUTST > 1) ? $clog2(MAX_OUTST) : 1;
  localparam int CNT_W = $clog2(MAX_OUTST + 1);

  // Issue info aligned with the registered bank output
  logic                         issue_q;
  logic [$clog2(NUM_BANKS)-1:0] bank_q;
  logic                         err_q;
  data_t                        push_data;
  resp_t                        push_resp;
  logic                         pop;
  // Response FIFO
  data_t                        fifo_data [MAX_OUTST];
  resp_t                        fifo_resp [MAX_OUTST];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  logic [CNT_W-1:0]             fill;

  // --------------------------------------------------------------------------
  // Bank data capture
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_q <= 1'b0;
    end else begin
      issue_q <= issue_i;
    end
  end

  always_ff @(posedge clk_i) begin
    bank_q <= bank_i;
    err_q  <= err_i;
  end

  // Error beat carries zero data
  assign push_data = err_q ? '0 : bank_rdata_i[bank_q];
  assign push_resp = err_q ? RESP_SLVERR : RESP_OKAY;

  // Beat in flight holds a slot
  assign space_o = ((fill + CNT_W'(issue_q)) < CNT_W'(MAX_OUTST));

  // --------------------------------------------------------------------------
  // In-order response FIFO
  // --------------------------------------------------------------------------

  assign r_valid_o = (fill != '0);
  assign r_data_o  = fifo_data[rd_ptr];
  assign r_resp_o  = fifo_resp[rd_ptr];
  assign pop       = r_valid_o & r_ready_i;

  always_ff @(posedge clk_i) begin
    if (issue_q) begin
      fifo_data[wr_ptr] <= push_data;
      fifo_resp[wr_ptr] <= push_resp;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (issue_q) begin
        wr_ptr <= (wr_ptr == PTR_W'(MAX_OUTST - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(MAX_OUTST - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (issue_q && !pop) begin
        fill <= fill + 1'b1;
      end else if (!issue_q && pop) begin
        fill <= fill - 1'b1;
      end
    end
  end

  // Dispatcher honours space, so a push never meets a full FIFO
  assert property (@(posedge clk_i) disable iff (rst_i) issue_q |-> (fill < CNT_W'(MAX_OUTST)));

endmodule

/* hw/mem_bank.sv */
module mem_bank #(
  parameter int BANK_WORDS = mem_sub_pkg::DEFAULT_BANK_WORDS
) (
  input  logic                          clk_i,
  input  logic                          we_i,
  input  logic                          re_i,
  input  logic [$clog2(BANK_WORDS)-1:0] row_i,
  input  mem_sub_pkg::data_t            wdata_i,
  input  mem_sub_pkg::strb_t            wstrb_i,
  output mem_sub_pkg::data_t            rdata_o
);

  import mem_sub_pkg::*;

  // Word storage, contents undefined until written
  data_t mem [BANK_WORDS];

  // --------------------------------------------------------------------------
  // Write port, one enable per byte lane
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read port
  // --------------------------------------------------------------------------

  // Registered read, holds until the next read
  // Same-edge write is not visible here, old word is returned
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem[row_i];
    end
  end

endmodule

/* hw/bank_dispatch.sv */
module bank_dispatch #(
  parameter int NUM_BANKS  = mem_sub_pkg::DEFAULT_NUM_BANKS,
  parameter int BANK_WORDS = mem_sub_pkg::DEFAULT_BANK_WORDS,
  parameter int MAX_OUTST  = mem_sub_pkg::DEFAULT_MAX_OUTST
) (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  // Write side
  input  logic                                           wr_aw_valid_i,
  input  mem_sub_pkg::addr_t                             wr_aw_addr_i,
  output logic                                           wr_aw_ready_o,
  input  logic                                           wr_w_valid_i,
  input  mem_sub_pkg::data_t                             wr_w_data_i,
  input  mem_sub_pkg::strb_t                             wr_w_strb_i,
  output logic                                           wr_w_ready_o,
  output logic                                           wr_b_valid_o,
  output mem_sub_pkg::resp_t                             wr_b_resp_o,
  input  logic                                           wr_b_ready_i,
  // Read side
  input  logic                                           rd_ar_valid_i,
  input  mem_sub_pkg::addr_t                             rd_ar_addr_i,
  output logic                                           rd_ar_ready_o,
  // Per-bank access
  output logic [NUM_BANKS-1:0]                           bank_we_o,
  output logic [NUM_BANKS-1:0]                           bank_re_o,
  output logic [NUM_BANKS-1:0][$clog2(BANK_WORDS)-1:0]   bank_row_o,
  output mem_sub_pkg::data_t [NUM_BANKS-1:0]             bank_wdata_o,
  output mem_sub_pkg::strb_t [NUM_BANKS-1:0]             bank_wstrb_o,
  // Read collector link
  output logic                                           rd_issue_o,
  output logic [$clog2(NUM_BANKS)-1:0]                   rd_bank_o,
  output logic                                           rd_err_o,
  input  logic                                           rd_space_i
);

  import mem_sub_pkg::*;

  localparam int    BANK_W    = $clog2(NUM_BANKS);
  localparam int    ROW_W     = $clog2(BANK_WORDS);
  localparam int    PTR_W     = (MAX_OUTST > 1) ? $clog2(MAX_OUTST) : 1;
  localparam int    CNT_W     = $clog2(MAX_OUTST + 1);
  localparam addr_t MEM_BYTES = addr_t'(NUM_BANKS * BANK_WORDS * 4);

  logic [BANK_W-1:0] wr_bank;
  logic [ROW_W-1:0]  wr_row;
  logic              wr_oor;
  logic [BANK_W-1:0] rd_bank;
  logic [ROW_W-1:0]  rd_row;
  logic              rd_oor;
  logic              wr_go;
  logic              rd_go;
  logic              rd_conflict;
  // B response queue
  resp_t             bq_mem [MAX_OUTST];
  logic [PTR_W-1:0]  bq_wr_ptr;
  logic [PTR_W-1:0]  bq_rd_ptr;
  logic [CNT_W-1:0]  bq_cnt;
  logic              bq_full;
  logic              bq_pop;

  // --------------------------------------------------------------------------
  // Address decode, word interleaved
  // --------------------------------------------------------------------------

  assign wr_bank = wr_aw_addr_i[2 +: BANK_W];
  assign wr_row  = wr_aw_addr_i[2 + BANK_W +: ROW_W];
  assign wr_oor  = (wr_aw_addr_i >= MEM_BYTES);
  assign rd_bank = rd_ar_addr_i[2 +: BANK_W];
  assign rd_row  = rd_ar_addr_i[2 + BANK_W +: ROW_W];
  assign rd_oor  = (rd_ar_addr_i >= MEM_BYTES);

  // Write needs AW and W together plus a free B slot
  assign bq_full       = (bq_cnt == CNT_W'(MAX_OUTST));
  assign wr_go         = wr_aw_valid_i & wr_w_valid_i & ~bq_full;
  assign wr_aw_ready_o = wr_go;
  assign wr_w_ready_o  = wr_go;

  // Bank has one row port, a write to another row of it holds the read back
  assign rd_conflict   = wr_go & ~wr_oor & ~rd_oor & (rd_bank == wr_bank) & (rd_row != wr_row);
  assign rd_ar_ready_o = rd_space_i & ~rd_conflict;
  assign rd_go         = rd_ar_valid_i & rd_ar_ready_o;

  assign rd_issue_o = rd_go;
  assign rd_bank_o  = rd_bank;
  assign rd_err_o   = rd_oor;

  always_comb begin
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_we_o[k]    = wr_go & ~wr_oor & (wr_bank == BANK_W'(k));
      bank_re_o[k]    = rd_go & ~rd_oor & (rd_bank == BANK_W'(k));
      // Same row on both when read and write share the bank
      bank_row_o[k]   = bank_we_o[k] ? wr_row : rd_row;
      bank_wdata_o[k] = wr_w_data_i;
      bank_wstrb_o[k] = wr_w_strb_i;
    end
  end

  // --------------------------------------------------------------------------
  // B response queue
  // --------------------------------------------------------------------------

  assign bq_pop       = wr_b_valid_o & wr_b_ready_i;
  assign wr_b_valid_o = (bq_cnt != '0);
  assign wr_b_resp_o  = bq_mem[bq_rd_ptr];

  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      bq_mem[bq_wr_ptr] <= wr_oor ? RESP_SLVERR : RESP_OKAY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bq_wr_ptr <= '0;
      bq_rd_ptr <= '0;
      bq_cnt    <= '0;
    end else begin
      if (wr_go) begin
        bq_wr_ptr <= (bq_wr_ptr == PTR_W'(MAX_OUTST - 1)) ? '0 : bq_wr_ptr + 1'b1;
      end
      if (bq_pop) begin
        bq_rd_ptr <= (bq_rd_ptr == PTR_W'(MAX_OUTST - 1)) ? '0 : bq_rd_ptr + 1'b1;
      end
      if (wr_go && !bq_pop) begin
        bq_cnt <= bq_cnt + 1'b1;
      end else if (!wr_go && bq_pop) begin
        bq_cnt <= bq_cnt - 1'b1;
      end
    end
  end

  // One bank at most per direction
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(bank_we_o));
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(bank_re_o));

endmodule

/* hw/axi_rw_split.sv */
module axi_rw_split #(
  parameter int MAX_OUTST = mem_sub_pkg::DEFAULT_MAX_OUTST
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // Slave port, write side
  input  logic               aw_valid_i,
  input  mem_sub_pkg::addr_t aw_addr_i,
  output logic               aw_ready_o,
  input  logic               w_valid_i,
  input  mem_sub_pkg::data_t w_data_i,
  input  mem_sub_pkg::strb_t w_strb_i,
  output logic               w_ready_o,
  output logic               b_valid_o,
  output mem_sub_pkg::resp_t b_resp_o,
  input  logic               b_ready_i,
  // Slave port, read side
  input  logic               ar_valid_i,
  input  mem_sub_pkg::addr_t ar_addr_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output mem_sub_pkg::data_t r_data_o,
  output mem_sub_pkg::resp_t r_resp_o,
  input  logic               r_ready_i,
  // Write master
  output logic               wr_aw_valid_o,
  output mem_sub_pkg::addr_t wr_aw_addr_o,
  input  logic               wr_aw_ready_i,
  output logic               wr_w_valid_o,
  output mem_sub_pkg::data_t wr_w_data_o,
  output mem_sub_pkg::strb_t wr_w_strb_o,
  input  logic               wr_w_ready_i,
  input  logic               wr_b_valid_i,
  input  mem_sub_pkg::resp_t wr_b_resp_i,
  output logic               wr_b_ready_o,
  // Read master
  output logic               rd_ar_valid_o,
  output mem_sub_pkg::addr_t rd_ar_addr_o,
  input  logic               rd_ar_ready_i,
  input  logic               rd_r_valid_i,
  input  mem_sub_pkg::data_t rd_r_data_i,
  input  mem_sub_pkg::resp_t rd_r_resp_i,
  output logic               rd_r_ready_o
);

  localparam int CNT_W = $clog2(MAX_OUTST + 1);

  logic [CNT_W-1:0] wr_cnt;
  logic [CNT_W-1:0] rd_cnt;
  logic             wr_full;
  logic             rd_full;
  logic             wr_req;
  logic             wr_rsp;
  logic             rd_req;
  logic             rd_rsp;

  // --------------------------------------------------------------------------
  // Write path: AW, W and B
  // --------------------------------------------------------------------------

  // Limit reached, hide the request from the dispatcher
  assign wr_full       = (wr_cnt == CNT_W'(MAX_OUTST));
  assign wr_aw_valid_o = aw_valid_i & ~wr_full;
  assign wr_w_valid_o  = w_valid_i & ~wr_full;
  assign aw_ready_o    = wr_aw_ready_i & ~wr_full;
  assign w_ready_o     = wr_w_ready_i & ~wr_full;
  assign wr_aw_addr_o  = aw_addr_i;
  assign wr_w_data_o   = w_data_i;
  assign wr_w_strb_o   = w_strb_i;

  assign b_valid_o    = wr_b_valid_i;
  assign b_resp_o     = wr_b_resp_i;
  assign wr_b_ready_o = b_ready_i;

  // Dispatcher only raises ready with AW and W both valid
  assign wr_req = aw_valid_i & aw_ready_o;
  assign wr_rsp = b_valid_o & b_ready_i;

  // --------------------------------------------------------------------------
  // Read path: AR and R
  // --------------------------------------------------------------------------

  assign rd_full       = (rd_cnt == CNT_W'(MAX_OUTST));
  assign rd_ar_valid_o = ar_valid_i & ~rd_full;
  assign ar_ready_o    = rd_ar_ready_i & ~rd_full;
  assign rd_ar_addr_o  = ar_addr_i;

  assign r_valid_o    = rd_r_valid_i;
  assign r_data_o     = rd_r_data_i;
  assign r_resp_o     = rd_r_resp_i;
  assign rd_r_ready_o = r_ready_i;

  assign rd_req = ar_valid_i & ar_ready_o;
  assign rd_rsp = r_valid_o & r_ready_i;

  // Outstanding counters, request in and response out in one cycle cancel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_cnt <= '0;
      rd_cnt <= '0;
    end else begin
      if (wr_req && !wr_rsp) begin
        wr_cnt <= wr_cnt + 1'b1;
      end else if (!wr_req && wr_rsp) begin
        wr_cnt <= wr_cnt - 1'b1;
      end
      if (rd_req && !rd_rsp) begin
        rd_cnt <= rd_cnt + 1'b1;
      end else if (!rd_req && rd_rsp) begin
        rd_cnt <= rd_cnt - 1'b1;
      end
    end
  end

  // No response without an accepted request
  assert property (@(posedge clk_i) disable iff (rst_i) b_valid_o |-> (wr_cnt != '0));
  assert property (@(posedge clk_i) disable iff (rst_i) r_valid_o |-> (rd_cnt != '0));
  // Counters stay within the limit
  assert property (@(posedge clk_i) disable iff (rst_i)
    (wr_cnt <= CNT_W'(MAX_OUTST)) && (rd_cnt <= CNT_W'(MAX_OUTST)));

endmodule

/* hw/mem_sub_pkg.sv */
package mem_sub_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One strobe bit per data byte
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  // Byte address on AW and AR
  typedef logic [ADDR_W-1:0] addr_t;
  // Data word on W and R
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  // Response code on B and R
  typedef logic [RESP_W-1:0] resp_t;

  // --------------------------------------------------------------------------
  // Response codes
  // --------------------------------------------------------------------------

  // Normal access completed
  localparam resp_t RESP_OKAY   = 2'b00;
  // Address beyond the end of the memory
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------------------------------------------------------------
  // Default sizes
  // --------------------------------------------------------------------------

  // Bank count, power of two
  localparam int DEFAULT_NUM_BANKS  = 4;
  // Words per bank, power of two
  localparam int DEFAULT_BANK_WORDS = 16;
  // Outstanding limit per direction
  localparam int DEFAULT_MAX_OUTST  = 4;

endpackage
